// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_rst_n
);

	// free running clock, low for the first half period
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// reset is low from time zero and released on a rising edge
	initial begin
		o_rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

// ==== bench/tb_second_if_dac.sv ====
`timescale 1ns/1ps

module tb_second_if_dac;

	import sif_pkg::*;

	localparam int CLK_PERIOD_NS = 8;
	localparam int RESET_CYCLES  = 4;
	// length of each stimulus phase in clocks
	localparam int GATE_CYCLES  = 200;
	localparam int ROT_CYCLES   = 64;
	localparam int RAND_CYCLES  = 2000;
	localparam int SAT_CYCLES   = 32;
	localparam int DRAIN_CYCLES = 16;
	localparam int RUN_CYCLES   = RESET_CYCLES + GATE_CYCLES + ROT_CYCLES + RAND_CYCLES
		+ 2 * SAT_CYCLES + DRAIN_CYCLES;
	// margin on top of the run for the end check
	localparam int WATCHDOG_NS  = (RUN_CYCLES + 200) * CLK_PERIOD_NS;
	// the mix drops the LO scale of LO_W-1 bits
	localparam int MIX_SH = 17;
	localparam logic signed [DAC_W-1:0] DAC_MAX = {1'b0, {(DAC_W-1){1'b1}}};
	localparam logic signed [DAC_W-1:0] DAC_MIN = {1'b1, {(DAC_W-1){1'b0}}};
	localparam logic signed [IQ_W-1:0]  IQ_MAX  = {1'b0, {(IQ_W-1){1'b1}}};
	localparam logic signed [IQ_W-1:0]  IQ_MIN  = {1'b1, {(IQ_W-1){1'b0}}};
	localparam logic signed [LO_W-1:0]  LO_MAX  = {1'b0, {(LO_W-1){1'b1}}};
	localparam int PH_GATE = 1;
	localparam int PH_ROT  = 2;
	localparam int PH_RAND = 3;
	localparam int PH_SAT  = 4;

	logic                      clk;
	logic                      rst_n;
	logic [1:0]                div_state = 2'd0;
	logic signed [DRIVE_W-1:0] drive_word;
	logic                      enable;
	lo_pair_t                  lo_in;
	ddr_word_t                 dac_word;
	int                        phase = 0;
	logic [31:0]               lfsr_state = 32'd79876;

	tb_clock_gen #(
		.PERIOD_NS    (CLK_PERIOD_NS),
		.RESET_CYCLES (RESET_CYCLES)
	) clock_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	second_if_dac #(
		.DRIVE_W (DRIVE_W),
		.LO_W    (LO_W),
		.DAC_W   (DAC_W)
	) DUT (
		.clk         (clk),
		.i_rst_n     (rst_n),
		.i_div_state (div_state),
		.i_drive     (drive_word),
		.i_enable    (enable),
		.i_lo        (lo_in),
		.o_dac       (dac_word)
	);

	task automatic stop_on_failure();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic report_value_error(input string name, input longint expected,
		input longint actual);
		$display("ERR time=%0t %s expected %0d actual %0d", $time, name, expected, actual);
		stop_on_failure();
	endtask

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// takes n bits with one LFSR step each and the newest bit ends up in the LSB
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	// quarter rotation table where pairs are written as {cos, sin}
	function automatic lo_pair_t rotate_quarter(input lo_pair_t lo, input logic [1:0] k);
		case (k)
			2'b00: return lo;
			2'b01: return {~lo.sin, lo.cos};
			2'b10: return {~lo.cos, ~lo.sin};
			default: return {lo.sin, ~lo.cos};
		endcase
	endfunction

	// early phase is (1 + j/16) times the rotated pair
	function automatic lo_pair_t interp_early(input lo_pair_t r);
		lo_pair_t p;
		p.cos = r.cos - (r.sin >>> 4);
		p.sin = r.sin + (r.cos >>> 4);
		return p;
	endfunction

	// late phase is (j + 1/16) times the rotated pair with negation by inversion
	function automatic lo_pair_t interp_late(input lo_pair_t r);
		lo_pair_t p;
		p.cos = ~r.sin + (r.cos >>> 4);
		p.sin = r.cos + (r.sin >>> 4);
		return p;
	endfunction

	function automatic logic signed [DAC_W-1:0] mix_sample(input drive_iq_t p,
		input lo_pair_t lo);
		longint acc;
		acc = (longint'(p.i) * longint'(lo.cos) + longint'(p.q) * longint'(lo.sin)) >>> MIX_SH;
		if (acc > longint'(DAC_MAX)) begin
			return DAC_MAX;
		end else if (acc < longint'(DAC_MIN)) begin
			return DAC_MIN;
		end
		return DAC_W'(acc);
	endfunction

	// LO and divider histories reach four edges back with index 0 the newest
	lo_pair_t                lo_hist [4] = '{default: '0};
	logic [1:0]              div_hist [4] = '{default: '0};
	// the mixers take the pair that stood three edges back
	drive_iq_t               pair_hist [3] = '{default: '0};
	logic [3:0]              rst_hist = '0;
	logic                    en_last = 1'b0;
	logic signed [IQ_W-1:0]  held_i = '0;
	logic                    model_ready = 1'b0;
	logic signed [DAC_W-1:0] exp_s0 = '0;
	logic signed [DAC_W-1:0] exp_s1 = '0;
	// counters that show each check was actually exercised
	int                      gate_hits = 0;
	int                      rot_changes = 0;
	logic signed [DAC_W-1:0] rot_last = '0;
	logic [3:0]              sat_seen = '0;

	// the free running divider also marks the I/Q slot with bit 0
	always @(posedge clk) begin
		div_state <= div_state + 2'd1;
	end

	// the reference model reads the inputs exactly as the DUT samples them on this edge
	always @(posedge clk) begin : model_step
		lo_pair_t                rot;
		lo_pair_t                early;
		lo_pair_t                late;
		drive_iq_t               pair_new;
		logic signed [IQ_W-1:0]  drive_top;
		logic signed [IQ_W-1:0]  held_new;
		logic signed [DAC_W-1:0] s0;
		logic signed [DAC_W-1:0] s1;

		// I waits for its Q and the pair only changes in the Q slot
		drive_top = drive_word[DRIVE_W-1:1];
		pair_new  = pair_hist[0];
		held_new  = held_i;
		if (!rst_n) begin
			pair_new = '0;
			held_new = '0;
		end else if (!div_state[0]) begin
			held_new = drive_top;
		end else begin
			pair_new = {held_i, drive_top};
		end

		// LO sampled four edges back and then the two DDR phases
		rot   = rst_hist[3] ? rotate_quarter(lo_hist[3], div_hist[3]) : '0;
		early = rst_hist[2] ? interp_early(rot) : '0;
		late  = rst_hist[2] ? interp_late(rot) : '0;
		// the mix uses the pair that stood three edges back
		s0 = (rst_hist[1] && rst_hist[0]) ? mix_sample(pair_hist[2], early) : '0;
		s1 = (rst_hist[1] && rst_hist[0]) ? mix_sample(pair_hist[2], late) : '0;

		if (rst_n && !enable && (s0 != '0 || s1 != '0)) begin
			gate_hits++;
		end
		if (phase == PH_ROT && s0 != rot_last) begin
			rot_changes++;
		end
		rot_last = s0;
		sat_seen = sat_seen | {s0 == DAC_MAX, s0 == DAC_MIN, s1 == DAC_MAX, s1 == DAC_MIN};

		exp_s0       <= (rst_n && enable) ? s0 : '0;
		exp_s1       <= (rst_n && enable) ? s1 : '0;
		lo_hist[3]   <= lo_hist[2];
		lo_hist[2]   <= lo_hist[1];
		lo_hist[1]   <= lo_hist[0];
		lo_hist[0]   <= lo_in;
		div_hist[3]  <= div_hist[2];
		div_hist[2]  <= div_hist[1];
		div_hist[1]  <= div_hist[0];
		div_hist[0]  <= div_state;
		pair_hist[2] <= pair_hist[1];
		pair_hist[1] <= pair_hist[0];
		pair_hist[0] <= pair_new;
		rst_hist     <= {rst_hist[2:0], rst_n};
		en_last      <= enable;
		held_i       <= held_new;
		model_ready  <= 1'b1;
	end

	// the word stays zero during reset and one edge past its release
	reset_zero: assert property (@(posedge clk)
		model_ready && !(rst_hist[0] && rst_hist[1]) |-> dac_word == '0)
		else report_value_error("o_dac", 0, longint'($sampled(dac_word)));

	// enable low on one edge silences the word from that edge on
	gate_zero: assert property (@(posedge clk) model_ready && !en_last |-> dac_word == '0)
		else report_value_error("o_dac", 0, longint'($sampled(dac_word)));

	s0_match: assert property (@(posedge clk) model_ready |-> dac_word.s0 == exp_s0)
		else report_value_error("o_dac.s0", longint'($sampled(exp_s0)),
			longint'($sampled(dac_word.s0)));

	s1_match: assert property (@(posedge clk) model_ready |-> dac_word.s1 == exp_s1)
		else report_value_error("o_dac.s1", longint'($sampled(exp_s1)),
			longint'($sampled(dac_word.s1)));

	task automatic drive_random(input logic en);
		@(posedge clk);
		drive_word <= DRIVE_W'(random_bits(DRIVE_W));
		lo_in.cos  <= LO_W'(random_bits(LO_W));
		lo_in.sin  <= LO_W'(random_bits(LO_W));
		enable     <= en;
	endtask

	// puts I or Q on the bus to match the divider slot that follows this edge
	task automatic drive_symbol(input logic signed [IQ_W-1:0] i_val,
		input logic signed [IQ_W-1:0] q_val, input lo_pair_t lo);
		logic [1:0] div_next;
		@(posedge clk);
		div_next = div_state + 2'd1;
		drive_word <= div_next[0] ? {q_val, 1'b0} : {i_val, 1'b0};
		lo_in      <= lo;
		enable     <= 1'b1;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
		stop_on_failure();
	end

	initial begin
		drive_word <= '0;
		lo_in      <= '0;
		enable     <= 1'b1;
		// live data goes in during reset while the output still has to stay at zero
		repeat (RESET_CYCLES) drive_random(1'b1);
		phase <= PH_GATE;
		repeat (GATE_CYCLES) drive_random(random_bits(2) != 32'd0);
		// Q held at zero so s0 follows the rotated early cosine alone
		phase <= PH_ROT;
		repeat (ROT_CYCLES) drive_symbol(17'sd40000, 17'sd0, {18'sd100000, 18'sd30000});
		phase <= PH_RAND;
		repeat (RAND_CYCLES) drive_random(1'b1);
		phase <= PH_SAT;
		repeat (SAT_CYCLES) drive_symbol(IQ_MAX, IQ_MAX, {LO_MAX, 18'sd0});
		repeat (SAT_CYCLES) drive_symbol(IQ_MIN, IQ_MIN, {LO_MAX, 18'sd0});
		repeat (DRAIN_CYCLES) drive_symbol('0, '0, '0);
		@(posedge clk);
		if (gate_hits > 0 && rot_changes >= 8 && (&sat_seen)) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("stimulus missed a check, gate %0d rotation %0d saturation %b",
				gate_hits, rot_changes, sat_seen);
			stop_on_failure();
		end
	end

endmodule

// ==== design/dac_output_gate.sv ====
`timescale 1ns/1ps

module dac_output_gate #(
	parameter int DAC_W = sif_pkg::DAC_W
) (
	input  logic                    clk,
	input  logic                    i_rst_n,
	// drive enable level, low silences the DAC
	input  logic                    i_enable,
	// first-half sample, from the early LO phase
	input  logic signed [DAC_W-1:0] i_s0,
	// second-half sample, from the late LO phase
	input  logic signed [DAC_W-1:0] i_s1,
	output sif_pkg::ddr_word_t      o_dac
);

	import sif_pkg::*;

	ddr_word_t gated;
	ddr_word_t dac_q;

	// both halves are zeroed together, so a disabled drive never
	// leaves half a word on the DAC
	always_comb begin
		if (i_enable) begin
			gated.s0 = i_s0;
			gated.s1 = i_s1;
		end else begin
			gated = '0;
		end
	end

	// the register lines the word up with the DAC clock and keeps the
	// gate glitch free at the pins
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			dac_q <= '0;
		end else begin
			dac_q <= gated;
		end
	end

	assign o_dac = dac_q;

endmodule

// ==== design/iq_deinterleave.sv ====
`timescale 1ns/1ps

module iq_deinterleave #(
	parameter int DRIVE_W = sif_pkg::DRIVE_W
) (
	input  logic                      clk,
	input  logic                      i_rst_n,
	// low while an I sample is on the drive bus, high for the Q sample
	input  logic                      i_iq_sel,
	input  logic signed [DRIVE_W-1:0] i_drive,
	output sif_pkg::drive_iq_t        o_pair
);

	import sif_pkg::*;

	// only the top bits of the drive word go on to the mixers
	localparam int KEEP_W = DRIVE_W - 1;

	logic signed [KEEP_W-1:0] drive_top;
	logic signed [KEEP_W-1:0] held_i;
	drive_iq_t                pair_q;

	// the LSB of the drive word is dropped here
	assign drive_top = i_drive[DRIVE_W-1 -: KEEP_W];

	// the I sample waits in held_i until its Q partner shows up
	// on the next clock
	// the pair register only loads on the Q edge, so each pair
	// stays on o_pair for two full cycles and the mixers
	// never see an I from one symbol next to a Q from another
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			held_i <= '0;
			pair_q <= '0;
		end else if (!i_iq_sel) begin
			// even edge, I sample on the bus
			held_i <= drive_top;
		end else begin
			// odd edge, Q sample on the bus
			// load it together with the I that came before it
			pair_q.i <= held_i;
			pair_q.q <= drive_top;
		end
	end

	assign o_pair = pair_q;

endmodule

// ==== design/level_mixer.sv ====
`timescale 1ns/1ps

module level_mixer #(
	parameter int IQ_W  = sif_pkg::IQ_W,
	parameter int LO_W  = sif_pkg::LO_W,
	parameter int DAC_W = sif_pkg::DAC_W
) (
	input  logic                    clk,
	input  logic                    i_rst_n,
	input  sif_pkg::drive_iq_t      i_pair,
	input  sif_pkg::lo_pair_t       i_lo,
	output logic signed [DAC_W-1:0] o_sample
);

	// full products and their sum, kept exact before scaling
	localparam int PROD_W = IQ_W + LO_W;
	localparam int SUM_W  = PROD_W + 1;
	// a full-scale LO is close to 2^(LO_W-1), so this shift takes it back out
	localparam int SCALE_SH = LO_W - 1;
	// bits above the sign of the DAC sample that have to agree with it
	localparam int HI_W = SUM_W - DAC_W + 1;

	logic signed [IQ_W-1:0]   pair_i;
	logic signed [IQ_W-1:0]   pair_q;
	logic signed [LO_W-1:0]   lo_cos;
	logic signed [LO_W-1:0]   lo_sin;
	logic signed [PROD_W-1:0] prod_ic_q;
	logic signed [PROD_W-1:0] prod_qs_q;
	logic signed [SUM_W-1:0]  sum;
	logic signed [SUM_W-1:0]  scaled;
	logic        [HI_W-1:0]   hi_bits;
	logic signed [DAC_W-1:0]  sat;

	assign pair_i = i_pair.i;
	assign pair_q = i_pair.q;
	assign lo_cos = i_lo.cos;
	assign lo_sin = i_lo.sin;

	// sum is sign extended from both products, so it cannot overflow
	assign sum     = prod_ic_q + prod_qs_q;
	assign scaled  = sum >>> SCALE_SH;
	assign hi_bits = scaled[SUM_W-1:DAC_W-1];

	// if every bit from the top down to the DAC sign bit agrees the
	// value fits, otherwise clamp to the limit on the side of the sign
	always_comb begin
		if ((&hi_bits) || !(|hi_bits)) begin
			sat = scaled[DAC_W-1:0];
		end else if (scaled[SUM_W-1]) begin
			sat = {1'b1, {(DAC_W-1){1'b0}}};
		end else begin
			sat = {1'b0, {(DAC_W-1){1'b1}}};
		end
	end

	// cycle one registers the two products, cycle two the saturated sum
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			prod_ic_q <= '0;
			prod_qs_q <= '0;
			o_sample  <= '0;
		end else begin
			prod_ic_q <= pair_i * lo_cos;
			prod_qs_q <= pair_q * lo_sin;
			o_sample  <= sat;
		end
	end

endmodule

// ==== design/lo_quarter_shift.sv ====
`timescale 1ns/1ps

module lo_quarter_shift #(
	parameter int LO_W = sif_pkg::LO_W
) (
	input  logic              clk,
	input  logic              i_rst_n,
	// divider state, which also walks the quarter-rate phasor
	input  logic [1:0]        i_div_state,
	input  sif_pkg::lo_pair_t i_lo,
	// phase for the first half of the DDR word
	output sif_pkg::lo_pair_t o_lo_early,
	// phase for the second half of the DDR word
	output sif_pkg::lo_pair_t o_lo_late
);

	import sif_pkg::*;

	// 1/16 stands in for the small phase step between the two DDR halves
	localparam int INTERP_SH = 4;

	lo_pair_t rot_d;
	lo_pair_t rot_q;
	lo_pair_t early_d;
	lo_pair_t early_q;
	lo_pair_t late_d;
	lo_pair_t late_q;

	logic signed [LO_W-1:0] rot_c;
	logic signed [LO_W-1:0] rot_s;
	logic signed [LO_W-1:0] rot_c_sh;
	logic signed [LO_W-1:0] rot_s_sh;

	// stage one multiplies the LO by exp(j*pi/2*k) with k from the divider
	// at a quarter of the clock rate this is only swaps and inversions,
	// so no multiplier is needed
	// inversion gives the negation one LSB low, which the LO can absorb
	always_comb begin
		case (i_div_state)
			2'b00: begin
				rot_d.cos = i_lo.cos;
				rot_d.sin = i_lo.sin;
			end
			2'b01: begin
				rot_d.cos = ~i_lo.sin;
				rot_d.sin = i_lo.cos;
			end
			2'b10: begin
				rot_d.cos = ~i_lo.cos;
				rot_d.sin = ~i_lo.sin;
			end
			default: begin
				rot_d.cos = i_lo.sin;
				rot_d.sin = ~i_lo.cos;
			end
		endcase
	end

	assign rot_c    = rot_q.cos;
	assign rot_s    = rot_q.sin;
	assign rot_c_sh = rot_c >>> INTERP_SH;
	assign rot_s_sh = rot_s >>> INTERP_SH;

	// stage two builds the two DDR phases
	// early is the rotated LO times (1 + j/16)
	// late is the rotated LO times (j + 1/16), a quarter turn further on
	// all sums wrap at LO_W bits
	always_comb begin
		early_d.cos = rot_c - rot_s_sh;
		early_d.sin = rot_s + rot_c_sh;
		late_d.cos  = ~rot_s + rot_c_sh;
		late_d.sin  = rot_c + rot_s_sh;
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rot_q   <= '0;
			early_q <= '0;
			late_q  <= '0;
		end else begin
			rot_q   <= rot_d;
			early_q <= early_d;
			late_q  <= late_d;
		end
	end

	assign o_lo_early = early_q;
	assign o_lo_late  = late_q;

endmodule

// ==== design/second_if_dac.sv ====
`timescale 1ns/1ps

module second_if_dac #(
	parameter int DRIVE_W = sif_pkg::DRIVE_W,
	parameter int LO_W    = sif_pkg::LO_W,
	parameter int DAC_W   = sif_pkg::DAC_W
) (
	input  logic                      clk,
	input  logic                      i_rst_n,
	// bit 0 is the I/Q strobe, both bits pick the quarter rotation
	input  logic [1:0]                i_div_state,
	// I and Q interleaved on alternate clocks
	input  logic signed [DRIVE_W-1:0] i_drive,
	input  logic                      i_enable,
	// low IF local oscillator
	input  sif_pkg::lo_pair_t         i_lo,
	// DDR word for the single DAC
	output sif_pkg::ddr_word_t        o_dac
);

	import sif_pkg::*;

	// the deinterleaver drops one LSB of the drive
	localparam int PAIR_W = DRIVE_W - 1;

	drive_iq_t               drive_pair;
	lo_pair_t                lo_early;
	lo_pair_t                lo_late;
	logic signed [DAC_W-1:0] mix_s0;
	logic signed [DAC_W-1:0] mix_s1;

	// drive path, 1 cycle after the Q sample
	iq_deinterleave #(
		.DRIVE_W (DRIVE_W)
	) deinterleave (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_iq_sel (i_div_state[0]),
		.i_drive  (i_drive),
		.o_pair   (drive_pair)
	);

	// LO path, 2 cycles, which lines it up with the pair for the mixers
	lo_quarter_shift #(
		.LO_W (LO_W)
	) lo_shift (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_div_state (i_div_state),
		.i_lo        (i_lo),
		.o_lo_early  (lo_early),
		.o_lo_late   (lo_late)
	);

	// one mixer per half of the DDR word, both fed the same drive pair
	level_mixer #(
		.IQ_W  (PAIR_W),
		.LO_W  (LO_W),
		.DAC_W (DAC_W)
	) mixer_s0 (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_pair   (drive_pair),
		.i_lo     (lo_early),
		.o_sample (mix_s0)
	);

	level_mixer #(
		.IQ_W  (PAIR_W),
		.LO_W  (LO_W),
		.DAC_W (DAC_W)
	) mixer_s1 (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_pair   (drive_pair),
		.i_lo     (lo_late),
		.o_sample (mix_s1)
	);

	// final register, the enable acts on the word one cycle later
	dac_output_gate #(
		.DAC_W (DAC_W)
	) out_gate (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_enable (i_enable),
		.i_s0     (mix_s0),
		.i_s1     (mix_s1),
		.o_dac    (o_dac)
	);

endmodule

// ==== design/sif_pkg.sv ====
package sif_pkg;

	// width of the interleaved drive word from the controller
	localparam int DRIVE_W = 18;

	// width of each local oscillator component, cosine and sine alike
	localparam int LO_W = 18;

	// the deinterleaver keeps the top bits of the drive word
	// and drops the single LSB below them
	localparam int IQ_W = DRIVE_W - 1;

	// width of one sample in the double data rate DAC word
	localparam int DAC_W = 16;

	// full-rate drive pair after deinterleaving
	// both halves change together, on the cycle after the Q sample
	typedef struct packed {
		logic signed [IQ_W-1:0] i;
		logic signed [IQ_W-1:0] q;
	} drive_iq_t;

	// complex local oscillator as a cosine and sine pair
	// negation of these components is bitwise inversion throughout,
	// so a negated component lands one LSB below the true value
	typedef struct packed {
		logic signed [LO_W-1:0] cos;
		logic signed [LO_W-1:0] sin;
	} lo_pair_t;

	// one DDR word for the DAC
	// s0 goes out in the first half of the DAC clock and s1 in the second
	typedef struct packed {
		logic signed [DAC_W-1:0] s0;
		logic signed [DAC_W-1:0] s1;
	} ddr_word_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the second IF DAC testbench with Verilator and runs it
# the exit status of the simulation binary is the result of the run
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module tb_second_if_dac \
	--Mdir obj_dir \
	-f second_if_dac.f

./obj_dir/Vtb_second_if_dac

// ==== second_if_dac.f ====
design/sif_pkg.sv
design/iq_deinterleave.sv
design/lo_quarter_shift.sv
design/level_mixer.sv
design/dac_output_gate.sv
design/second_if_dac.sv
bench/tb_clock_gen.sv
bench/tb_second_if_dac.sv
